// ==== logic/sched_pkg.sv ====
package sched_pkg;

  // time stamp or current time in clock cycles
  typedef logic [31:0] time_t;

  // command bus address whose low bits pick a pin bank
  typedef logic [15:0] addr_t;

  // command bus data word holding one bank of pin values
  typedef logic [31:0] data_t;

  // full command word as pushed by the host
  typedef logic [79:0] cmd_t;

  // field positions inside cmd_t
  // layout from msb down is time, data, address
  localparam int TIME_H = 79;
  localparam int TIME_L = 48;
  localparam int DATA_H = 47;
  localparam int DATA_L = 16;
  localparam int ADDR_H = 15;
  localparam int ADDR_L = 0;

  // one-hot scheduler states
  typedef enum logic [4:0] {
    ST_EXEC_WAIT = 5'b00001,
    ST_FETCH     = 5'b00010,
    ST_FIFO_WAIT = 5'b00100,
    ST_EXEC      = 5'b01000,
    ST_IDLE      = 5'b10000
  } sched_state_t;

endpackage

// ==== logic/time_base.sv ====
`timescale 1ns/1ps

module time_base (
  input  logic             clk,
  input  logic             rst,
  input  logic             run,
  input  logic             time_clear,
  output sched_pkg::time_t current_time
);

  // free-running cycle counter
  sched_pkg::time_t count_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count_q <= '0;
    end else if (time_clear) begin
      // clear wins over run so a restart begins at exactly zero
      count_q <= '0;
    end else if (run) begin
      count_q <= count_q + sched_pkg::time_t'(1);
    end
  end

  // scheduler and host both see the same count
  assign current_time = count_q;

endmodule

// ==== logic/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            cmd_push,
  input  sched_pkg::cmd_t cmd_in,
  input  logic            cmd_fifo_rd_en,
  output sched_pkg::cmd_t cmd_fifo_dout,
  output logic            cmd_fifo_empty,
  output logic            cmd_fifo_valid,
  output logic            credit_return
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // entry storage
  sched_pkg::cmd_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // a pop only happens when there is something to pop
  logic do_pop;

  assign do_pop = cmd_fifo_rd_en && !cmd_fifo_empty;

  // overflow is kept away by the host credit rule
  assign cmd_fifo_empty = (count == '0);

  always_ff @(posedge clk) begin
    if (cmd_push) begin
      mem[wr_ptr] <= cmd_in;
    end
    // head entry is registered onto dout
    if (do_pop) begin
      cmd_fifo_dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      cmd_fifo_valid <= 1'b0;
      credit_return  <= 1'b0;
    end else begin
      if (cmd_push) begin
        // wrap by hand so depth need not be a power of two
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      // occupancy tracks push and pop in the same cycle
      case ({cmd_push, do_pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
      // valid and credit both mark the freed entry for one cycle
      cmd_fifo_valid <= do_pop;
      credit_return  <= do_pop;
    end
  end

endmodule

// ==== logic/scheduler.sv ====
`timescale 1ns/1ps

module scheduler (
  input  logic             clk,
  input  logic             rst,
  input  sched_pkg::time_t current_time,
  input  sched_pkg::cmd_t  cmd_fifo_dout,
  input  logic             cmd_fifo_empty,
  input  logic             cmd_fifo_valid,
  output logic             cmd_fifo_rd_en,
  output sched_pkg::addr_t cmd_bus_addr,
  output sched_pkg::data_t cmd_bus_data,
  output logic             cmd_bus_en,
  output logic             cmd_bus_wr
);

  sched_pkg::sched_state_t state;
  sched_pkg::sched_state_t next_state;

  // the one command in flight
  sched_pkg::cmd_t command;

  // load strobe for the command register
  logic load_cmd;

  // stamp of the held command
  sched_pkg::time_t cmd_time;

  // high once the held command is due
  logic time_due;

  assign cmd_time = command[sched_pkg::TIME_H:sched_pkg::TIME_L];

  // unsigned compare makes a zero stamp due at once
  assign time_due = (current_time >= cmd_time);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= sched_pkg::ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // next state and combinational strobes
  always_comb begin
    next_state     = state;
    cmd_fifo_rd_en = 1'b0;
    cmd_bus_en     = 1'b0;
    cmd_bus_wr     = 1'b0;
    load_cmd       = 1'b0;
    case (state)
      sched_pkg::ST_IDLE: begin
        next_state = sched_pkg::ST_FETCH;
      end
      sched_pkg::ST_FETCH: begin
        // ask for the head entry as soon as one is there
        if (!cmd_fifo_empty) begin
          cmd_fifo_rd_en = 1'b1;
          next_state     = sched_pkg::ST_FIFO_WAIT;
        end
      end
      sched_pkg::ST_FIFO_WAIT: begin
        // data shows up one cycle after the read
        if (cmd_fifo_valid) begin
          load_cmd   = 1'b1;
          next_state = sched_pkg::ST_EXEC;
        end
      end
      sched_pkg::ST_EXEC: begin
        // hold here until the stamp comes due
        if (time_due) begin
          cmd_bus_en = 1'b1;
          cmd_bus_wr = 1'b1;
          next_state = sched_pkg::ST_EXEC_WAIT;
        end
      end
      sched_pkg::ST_EXEC_WAIT: begin
        // settle cycle while addr and data stay put on the bus
        next_state = sched_pkg::ST_FETCH;
      end
      default: begin
        next_state = sched_pkg::ST_IDLE;
      end
    endcase
  end

  // command register loads from the fifo head
  always_ff @(posedge clk) begin
    if (load_cmd) begin
      command <= cmd_fifo_dout;
    end
  end

  // bus fields come straight from the held command
  assign cmd_bus_addr = command[sched_pkg::ADDR_H:sched_pkg::ADDR_L];
  assign cmd_bus_data = command[sched_pkg::DATA_H:sched_pkg::DATA_L];

endmodule

// ==== logic/pin_control.sv ====
`timescale 1ns/1ps

module pin_control #(
  parameter int NUM_BANKS = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  sched_pkg::addr_t       cmd_bus_addr,
  input  sched_pkg::data_t       cmd_bus_data,
  input  logic                   cmd_bus_en,
  input  logic                   cmd_bus_wr,
  output logic [NUM_BANKS*32-1:0] pins
);

  // one select line per bank
  logic [NUM_BANKS-1:0] bank_sel;

  // write cycle on the command bus
  logic wr_hit;

  assign wr_hit = cmd_bus_en && cmd_bus_wr;

  // addresses at or beyond NUM_BANKS match no bank and are dropped
  always_comb begin
    bank_sel = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (wr_hit && (cmd_bus_addr == sched_pkg::addr_t'(b))) begin
        bank_sel[b] = 1'b1;
      end
    end
  end

  // pins update on the edge after the write strobe
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pins <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        // unselected banks hold their value
        if (bank_sel[b]) begin
          pins[b*32 +: 32] <= cmd_bus_data;
        end
      end
    end
  end

endmodule

// ==== logic/timed_cmd_top.sv ====
`timescale 1ns/1ps

module timed_cmd_top #(
  parameter int FIFO_DEPTH = 8,
  parameter int NUM_BANKS  = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    run,
  input  logic                    time_clear,
  input  logic                    cmd_push,
  input  sched_pkg::cmd_t         cmd_in,
  output logic                    credit_return,
  output sched_pkg::time_t        current_time,
  output logic [NUM_BANKS*32-1:0] pins
);

  // fifo to scheduler
  sched_pkg::cmd_t  cmd_fifo_dout;
  logic             cmd_fifo_empty;
  logic             cmd_fifo_valid;
  logic             cmd_fifo_rd_en;

  // internal command bus
  sched_pkg::addr_t cmd_bus_addr;
  sched_pkg::data_t cmd_bus_data;
  logic             cmd_bus_en;
  logic             cmd_bus_wr;

  time_base u_time_base (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .time_clear   (time_clear),
    .current_time (current_time)
  );

  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk            (clk),
    .rst            (rst),
    .cmd_push       (cmd_push),
    .cmd_in         (cmd_in),
    .cmd_fifo_rd_en (cmd_fifo_rd_en),
    .cmd_fifo_dout  (cmd_fifo_dout),
    .cmd_fifo_empty (cmd_fifo_empty),
    .cmd_fifo_valid (cmd_fifo_valid),
    .credit_return  (credit_return)
  );

  scheduler u_scheduler (
    .clk            (clk),
    .rst            (rst),
    .current_time   (current_time),
    .cmd_fifo_dout  (cmd_fifo_dout),
    .cmd_fifo_empty (cmd_fifo_empty),
    .cmd_fifo_valid (cmd_fifo_valid),
    .cmd_fifo_rd_en (cmd_fifo_rd_en),
    .cmd_bus_addr   (cmd_bus_addr),
    .cmd_bus_data   (cmd_bus_data),
    .cmd_bus_en     (cmd_bus_en),
    .cmd_bus_wr     (cmd_bus_wr)
  );

  pin_control #(
    .NUM_BANKS (NUM_BANKS)
  ) u_pin_control (
    .clk          (clk),
    .rst          (rst),
    .cmd_bus_addr (cmd_bus_addr),
    .cmd_bus_data (cmd_bus_data),
    .cmd_bus_en   (cmd_bus_en),
    .cmd_bus_wr   (cmd_bus_wr),
    .pins         (pins)
  );

endmodule

// ==== verif/timed_cmd_tb.sv ====
`timescale 1ns/1ps

module timed_cmd_tb;

  localparam int FIFO_DEPTH  = 8;
  localparam int NUM_BANKS   = 2;
  localparam int PINS_W      = NUM_BANKS * 32;
  // counted from the push cycle itself as cycle one
  localparam int IMM_LATENCY = 5;
  localparam int T3_OFFSET   = 50;
  localparam int T4_BASE     = 20;
  localparam int T4_STEP     = 10;
  localparam int T5_BASE     = 200;
  localparam int T5_STEP     = 8;
  // all stamps of the tests plus 200 cycles for each of the five tests
  localparam int WATCHDOG_CYCLES = T3_OFFSET + 6 * T4_BASE + 15 * T4_STEP +
                                   FIFO_DEPTH * T5_BASE +
                                   T5_STEP * FIFO_DEPTH * (FIFO_DEPTH - 1) / 2 + 5 * 200;

  logic              clk;
  logic              rst;
  logic              run;
  logic              time_clear;
  logic              cmd_push;
  sched_pkg::cmd_t   cmd_in;
  logic              credit_return;
  sched_pkg::time_t  current_time;
  logic [PINS_W-1:0] pins;

  // host model state
  logic [PINS_W-1:0] expected_pins;
  int                pushes_sent;
  int                credits_back = 0;
  int                seed = 32'h4bb5;

  timed_cmd_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .NUM_BANKS  (NUM_BANKS)
  ) DUT (
    .clk           (clk),
    .rst           (rst),
    .run           (run),
    .time_clear    (time_clear),
    .cmd_push      (cmd_push),
    .cmd_in        (cmd_in),
    .credit_return (credit_return),
    .current_time  (current_time),
    .pins          (pins)
  );

  always #4 clk = ~clk;

  // each pop pulse is counted once at the falling edge
  always @(negedge clk) begin
    if (!rst && credit_return) begin
      credits_back <= credits_back + 1;
    end
  end

  function automatic int credits_free();
    return FIFO_DEPTH - pushes_sent + credits_back;
  endfunction

  task automatic report_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_pins(input string name, input logic [PINS_W-1:0] exp,
                            input logic [PINS_W-1:0] act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  // with at_least set the update time must not come before the stamp
  task automatic check_time(input string name, input sched_pkg::time_t exp,
                            input sched_pkg::time_t act, input logic at_least);
    if (at_least ? (act < exp) : (act !== exp)) begin
      $display("mismatch %s expected %s%0d actual %0d", name, at_least ? ">= " : "", exp, act);
      report_failure();
    end
  endtask

  task automatic check_credits(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("mismatch %s expected %0d actual %0d", name, exp, act);
      report_failure();
    end
  endtask

  function automatic sched_pkg::cmd_t make_cmd(input sched_pkg::time_t t,
                                               input sched_pkg::data_t d,
                                               input sched_pkg::addr_t a);
    sched_pkg::cmd_t c;
    c = '0;
    c[sched_pkg::TIME_H:sched_pkg::TIME_L] = t;
    c[sched_pkg::DATA_H:sched_pkg::DATA_L] = d;
    c[sched_pkg::ADDR_H:sched_pkg::ADDR_L] = a;
    return c;
  endfunction

  function automatic sched_pkg::data_t fresh_data(input sched_pkg::data_t avoid);
    sched_pkg::data_t d;
    d = $random(seed);
    // same value as the bank holds would hide the write
    if (d == avoid) begin
      d = ~d;
    end
    return d;
  endfunction

  // host only pushes while it holds a credit
  task automatic push_cmd(input sched_pkg::cmd_t c);
    @(posedge clk);
    while (credits_free() == 0) begin
      @(posedge clk);
    end
    cmd_push    <= 1'b1;
    cmd_in      <= c;
    pushes_sent = pushes_sent + 1;
    @(posedge clk);
    cmd_push <= 1'b0;
  endtask

  // returns the time seen at the first falling edge with new pins
  task automatic watch_pin_change(input string name, input int limit,
                                  output sched_pkg::time_t seen);
    int n;
    n = 0;
    @(negedge clk);
    while (pins === expected_pins) begin
      if (n == limit) begin
        $display("%s: pins did not change within %0d cycles", name, limit);
        report_failure();
      end
      n = n + 1;
      @(negedge clk);
    end
    seen = current_time;
  endtask

  // every pushed entry popped and credited
  task automatic collect_credits(input string name, input int limit);
    int n;
    n = 0;
    @(posedge clk);
    while (credits_free() != FIFO_DEPTH) begin
      if (n == limit) begin
        $display("%s: credits did not all return within %0d cycles", name, limit);
        report_failure();
      end
      n = n + 1;
      @(posedge clk);
    end
  endtask

  task automatic reset_state();
    @(negedge clk);
    check_pins("reset pins", '0, pins);
    check_time("reset time", '0, current_time, 1'b0);
    check_credits("reset credits", 0, credits_back);
  endtask

  // stamp zero goes out even with run low
  task automatic immediate_command();
    sched_pkg::data_t d;
    d = fresh_data(expected_pins[0 +: 32]);
    push_cmd(make_cmd('0, d, 16'd0));
    for (int cyc = 2; cyc <= IMM_LATENCY; cyc++) begin
      @(negedge clk);
      if (cyc < IMM_LATENCY) begin
        check_pins("immediate early", expected_pins, pins);
      end
    end
    expected_pins[0 +: 32] = d;
    check_pins("immediate", expected_pins, pins);
  endtask

  task automatic timed_release();
    sched_pkg::time_t stamp;
    sched_pkg::time_t seen;
    sched_pkg::data_t d;
    @(posedge clk);
    run <= 1'b1;
    @(negedge clk);
    stamp = current_time + T3_OFFSET;
    d     = fresh_data(expected_pins[32 +: 32]);
    push_cmd(make_cmd(stamp, d, 16'd1));
    watch_pin_change("timed release", T3_OFFSET + 200, seen);
    // pins move on the edge after the strobe and time steps on that edge too
    check_time("timed release", stamp + 1, seen, 1'b1);
    expected_pins[32 +: 32] = d;
    check_pins("timed release", expected_pins, pins);
  endtask

  task automatic ordering_and_banks();
    sched_pkg::time_t  now;
    sched_pkg::time_t  seen;
    sched_pkg::data_t  d;
    sched_pkg::time_t  stamp [6];
    sched_pkg::addr_t  addr [6];
    logic [PINS_W-1:0] state [6];
    logic [PINS_W-1:0] model;
    @(negedge clk);
    now   = current_time;
    model = expected_pins;
    // fifth write is out of range and the sixth shows it has been retired
    addr = '{16'd0, 16'd1, 16'd0, 16'd1, 16'(NUM_BANKS), 16'd1};
    for (int i = 0; i < 6; i++) begin
      stamp[i] = now + T4_BASE + i * T4_STEP;
      d        = fresh_data(model[(addr[i] % NUM_BANKS) * 32 +: 32]);
      if (addr[i] < NUM_BANKS) begin
        model[addr[i] * 32 +: 32] = d;
      end
      state[i] = model;
      push_cmd(make_cmd(stamp[i], d, addr[i]));
    end
    for (int i = 0; i < 6; i++) begin
      if (i == 4) begin
        // with one command in flight the last pop means write four is done
        collect_credits("ordering drain", T4_BASE + T4_STEP + 200);
        @(negedge clk);
        check_pins("out of range write", expected_pins, pins);
      end else begin
        watch_pin_change("ordering", T4_BASE + T4_STEP + 200, seen);
        check_time("ordering", stamp[i] + 1, seen, 1'b1);
        expected_pins = state[i];
        check_pins("ordering", expected_pins, pins);
      end
    end
  endtask

  task automatic credit_flow();
    logic [PINS_W-1:0] model;
    sched_pkg::data_t  d;
    sched_pkg::addr_t  a;
    // freeze time at zero so every stamp is far ahead
    @(posedge clk);
    run        <= 1'b0;
    time_clear <= 1'b1;
    @(posedge clk);
    time_clear <= 1'b0;
    check_credits("credit flow start", FIFO_DEPTH, credits_free());
    model = expected_pins;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      a = sched_pkg::addr_t'(i % NUM_BANKS);
      d = fresh_data(model[a * 32 +: 32]);
      model[a * 32 +: 32] = d;
      push_cmd(make_cmd(T5_BASE + i * T5_STEP, d, a));
    end
    // scheduler holds the first entry while the rest wait in the FIFO
    repeat (4 * T5_STEP) @(posedge clk);
    check_credits("credit flow stall", 1, credits_free());
    @(negedge clk);
    check_pins("credit flow stall", expected_pins, pins);
    @(posedge clk);
    run <= 1'b1;
    collect_credits("credit flow release", T5_BASE + FIFO_DEPTH * T5_STEP + 200);
    // last entry is loaded but may still wait for its stamp
    @(negedge clk);
    for (int n = 0; n < 200 && pins !== model; n++) begin
      @(negedge clk);
    end
    expected_pins = model;
    check_pins("credit flow final", expected_pins, pins);
    // no stray credit once the last entry has gone out
    check_credits("credit flow final", FIFO_DEPTH, credits_free());
  endtask

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    run           = 1'b0;
    time_clear    = 1'b0;
    cmd_push      = 1'b0;
    cmd_in        = '0;
    pushes_sent   = 0;
    expected_pins = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    reset_state();
    immediate_command();
    timed_release();
    ordering_and_banks();
    credit_flow();
    $display("Done: no errors");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES + 8) @(posedge clk);
    $display("watchdog: tests still running after %0d cycles", WATCHDOG_CYCLES + 8);
    report_failure();
  end

endmodule

// ==== files.f ====
logic/sched_pkg.sv
logic/time_base.sv
logic/cmd_fifo.sv
logic/scheduler.sv
logic/pin_control.sv
logic/timed_cmd_top.sv
verif/timed_cmd_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module timed_cmd_tb -f files.f -o sim_timed_cmd

# the simulator exits nonzero on failure, so keep its output for the search
output=$(./obj_dir/sim_timed_cmd 2>&1) || true
echo "$output"

if grep -qx "Done: no errors" <<< "$output"; then
  exit 0
else
  exit 1
fi
